//--- source/fpMulPkg.sv
package fpMulPkg;

	// binary16 format
	localparam int ExpWidth = 5;
	localparam int ManWidth = 10;
	localparam int DataWidth = 1 + ExpWidth + ManWidth;
	localparam int ExpBias = 15;
	localparam int ExpMax = (1 << ExpWidth) - 1;		// All-ones exponent, inf or NaN

	// Flag vector layout
	localparam int FlagWidth = 4;
	localparam int FlagInvalid = 3;
	localparam int FlagOverflow = 2;
	localparam int FlagUnderflow = 1;
	localparam int FlagInexact = 0;

	localparam logic [DataWidth-1:0] CanonNaN = 16'h7E00;	// Quiet NaN, no payload

	// Lane array sizing
	localparam int NumLanes = 4;
	localparam int LaneIdxWidth = 2;
	localparam int LaneDepth = 4;				// Also the initial credit per lane
	localparam int InQueueDepth = 4;			// Also the initial input credit
	localparam int OutCredits = 4;

	// Derived pointer and counter widths
	localparam int QueuePtrWidth = $clog2(InQueueDepth);
	localparam int QueueCntWidth = $clog2(InQueueDepth + 1);
	localparam int LanePtrWidth = $clog2(LaneDepth);
	localparam int LaneCntWidth = $clog2(LaneDepth + 1);
	localparam int OutCntWidth = $clog2(OutCredits + 1);

	typedef enum logic [1:0] {
		classZero,					// Zero or flushed subnormal
		classNormal,
		classInf,
		classNaN
	} opClass;

endpackage

//--- source/fpMulDispatch.sv
`timescale 1ns/1ps

module fpMulDispatch import fpMulPkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	input  logic [DataWidth-1:0] inA,
	input  logic [DataWidth-1:0] inB,
	output logic inCredit,
	output logic [NumLanes-1:0] issueValid,
	output logic [NumLanes-1:0][DataWidth-1:0] issueA,
	output logic [NumLanes-1:0][DataWidth-1:0] issueB,
	input  logic [NumLanes-1:0] laneCredit
);

	logic [DataWidth-1:0] qA [InQueueDepth];
	logic [DataWidth-1:0] qB [InQueueDepth];
	logic [QueuePtrWidth-1:0] wrPtr;
	logic [QueuePtrWidth-1:0] rdPtr;
	logic [QueueCntWidth-1:0] qCnt;
	logic [LaneIdxWidth-1:0] rrPtr;				// Next lane in strict turn
	logic [NumLanes-1:0][LaneCntWidth-1:0] laneCnt;
	logic issue;

	// Head leaves only when the lane in turn still has FIFO room
	assign issue = (qCnt != '0) && (laneCnt[rrPtr] != '0);

	always_ff @(posedge clk) begin
		if (inValid) begin
			qA[wrPtr] <= inA;
			qB[wrPtr] <= inB;
		end
		if (issue) begin
			issueA[rrPtr] <= qA[rdPtr];
			issueB[rrPtr] <= qB[rdPtr];
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			qCnt <= '0;
			rrPtr <= '0;
			inCredit <= 1'b0;
			issueValid <= '0;
		end else begin
			wrPtr <= wrPtr + QueuePtrWidth'(inValid);
			rdPtr <= rdPtr + QueuePtrWidth'(issue);
			qCnt <= qCnt + QueueCntWidth'(inValid) - QueueCntWidth'(issue);
			inCredit <= issue;					// One credit back per pair issued
			issueValid <= '0;
			if (issue) begin
				issueValid[rrPtr] <= 1'b1;
				rrPtr <= (rrPtr == LaneIdxWidth'(NumLanes - 1)) ? '0 : rrPtr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < NumLanes; i++) begin
				laneCnt[i] <= LaneCntWidth'(LaneDepth);
			end
		end else begin
			for (int i = 0; i < NumLanes; i++) begin
				laneCnt[i] <= laneCnt[i] + LaneCntWidth'(laneCredit[i])
					- LaneCntWidth'(issue && (rrPtr == LaneIdxWidth'(i)));
			end
		end
	end

	// Source must respect its credits
	assert property (@(posedge clk) disable iff (!arstN)
		inValid |-> qCnt != QueueCntWidth'(InQueueDepth));

	for (genvar gi = 0; gi < NumLanes; gi++) begin : genCreditChk
		assert property (@(posedge clk) disable iff (!arstN)
			laneCnt[gi] <= LaneCntWidth'(LaneDepth));	// Collector returns no spare credit
	end

endmodule

//--- source/fpMulPrepare.sv
`timescale 1ns/1ps

module fpMulPrepare import fpMulPkg::*; (
	input  logic [DataWidth-1:0] a,
	input  logic [DataWidth-1:0] b,
	output opClass classA,
	output opClass classB,
	output logic [ManWidth:0] manA,
	output logic [ManWidth:0] manB,
	output logic [ExpWidth+1:0] expSum,
	output logic sign,
	output logic [DataWidth-1:0] specialResult,
	output logic specialValid,
	output logic invalid
);

	logic [ExpWidth-1:0] expA;
	logic [ExpWidth-1:0] expB;

	function automatic opClass classify(input logic [DataWidth-1:0] x);
		logic [ExpWidth-1:0] e;
		logic [ManWidth-1:0] f;
		e = x[DataWidth-2 -: ExpWidth];
		f = x[ManWidth-1:0];
		if (e == '0) begin
			return classZero;					// Subnormals flush here
		end
		if (e == '1) begin
			return (f == '0) ? classInf : classNaN;
		end
		return classNormal;
	endfunction

	assign expA = a[DataWidth-2 -: ExpWidth];
	assign expB = b[DataWidth-2 -: ExpWidth];
	assign classA = classify(a);
	assign classB = classify(b);
	assign manA = {1'b1, a[ManWidth-1:0]};		// Hidden bit restored
	assign manB = {1'b1, b[ManWidth-1:0]};
	assign sign = a[DataWidth-1] ^ b[DataWidth-1];

	// Biased product exponent, may go negative
	assign expSum = (ExpWidth+2)'(expA) + (ExpWidth+2)'(expB) - (ExpWidth+2)'(ExpBias);

	always_comb begin
		specialValid = (classA != classNormal) || (classB != classNormal);
		invalid = 1'b0;
		specialResult = {sign, {(DataWidth-1){1'b0}}};	// Signed zero by default
		if ((classA == classNaN) || (classB == classNaN)) begin
			specialResult = CanonNaN;
			invalid = 1'b1;
		end else if (((classA == classInf) && (classB == classZero)) ||
				((classA == classZero) && (classB == classInf))) begin
			specialResult = CanonNaN;			// inf * 0
			invalid = 1'b1;
		end else if ((classA == classInf) || (classB == classInf)) begin
			specialResult = {sign, {ExpWidth{1'b1}}, {ManWidth{1'b0}}};
		end
	end

endmodule

//--- source/fpMulRound.sv
`timescale 1ns/1ps

module fpMulRound import fpMulPkg::*; (
	input  logic [ManWidth:0] roundM,			// Normalized mantissa, hidden bit at top
	input  logic [ManWidth:0] roundMP,			// Normalized mantissa plus one
	input  logic [ExpWidth+1:0] roundE,			// Biased exponent, two's complement
	input  logic [ExpWidth+1:0] roundEP,		// Exponent plus one
	input  logic sign,
	input  logic roundUp,
	input  logic inexact,
	output logic [DataWidth-1:0] result,
	output logic [FlagWidth-1:0] flags
);

	logic [ManWidth:0] preShiftM;
	logic [ManWidth:0] finalM;
	logic [ExpWidth+1:0] finalE;
	logic carry;

	assign preShiftM = roundUp ? roundMP : roundM;

	// 1.11..1 plus one wraps and loses the hidden bit
	assign carry = !preShiftM[ManWidth];
	assign finalM = carry ? {1'b1, preShiftM[ManWidth:1]} : preShiftM;
	assign finalE = carry ? roundEP : roundE;

	always_comb begin
		flags = '0;
		flags[FlagInexact] = inexact;
		if (!finalE[ExpWidth+1] && (finalE >= (ExpWidth+2)'(ExpMax))) begin
			result = {sign, {ExpWidth{1'b1}}, {ManWidth{1'b0}}};	// Signed infinity
			flags[FlagOverflow] = 1'b1;
			flags[FlagInexact] = 1'b1;
		end else if (finalE[ExpWidth+1] || (finalE == '0)) begin
			result = {sign, {(DataWidth-1){1'b0}}};	// Flush to signed zero
			flags[FlagUnderflow] = 1'b1;
			flags[FlagInexact] = 1'b1;
		end else begin
			result = {sign, finalE[ExpWidth-1:0], finalM[ManWidth-1:0]};
		end
	end

endmodule

//--- source/fpMulLane.sv
`timescale 1ns/1ps

module fpMulLane import fpMulPkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic issueValid,
	input  logic [DataWidth-1:0] issueA,
	input  logic [DataWidth-1:0] issueB,
	output logic laneValid,
	output logic [DataWidth-1:0] laneResult,
	output logic [FlagWidth-1:0] laneFlags,
	input  logic lanePop
);

	logic [ManWidth:0] manA, manB;
	logic [ExpWidth+1:0] expSum;
	logic sign, specialValid, invalid;
	logic [DataWidth-1:0] specialResult;

	logic valid1, sign1, specialValid1, invalid1;
	logic [ManWidth:0] manA1, manB1;
	logic [ExpWidth+1:0] expSum1;
	logic [DataWidth-1:0] specialResult1;

	logic [2*ManWidth+1:0] product;
	logic prodHigh, guard, roundBit, sticky;
	logic [ManWidth:0] normM;
	logic [ExpWidth+1:0] normE;

	logic valid2, sign2, specialValid2, invalid2, roundUp2, inexact2;
	logic [ManWidth:0] roundM2, roundMP2;
	logic [ExpWidth+1:0] roundE2, roundEP2;
	logic [DataWidth-1:0] specialResult2, roundResult;
	logic [FlagWidth-1:0] roundFlags, specialFlags;

	logic [DataWidth+FlagWidth-1:0] fifoMem [LaneDepth];
	logic [DataWidth+FlagWidth-1:0] fifoData;
	logic [LanePtrWidth-1:0] wrPtr, rdPtr;
	logic [LaneCntWidth-1:0] fifoCnt;

	fpMulPrepare prepare_i (.a(issueA), .b(issueB), .classA(), .classB(), .manA, .manB,
		.expSum, .sign, .specialResult, .specialValid, .invalid);

	// Stage 2 product lies in [1,4)
	assign product = (2*ManWidth+2)'(manA1) * (2*ManWidth+2)'(manB1);
	assign prodHigh = product[2*ManWidth+1];
	assign normM = prodHigh ? product[2*ManWidth+1 -: ManWidth+1]
		: product[2*ManWidth -: ManWidth+1];
	assign normE = expSum1 + (ExpWidth+2)'(prodHigh);
	assign guard = prodHigh ? product[ManWidth] : product[ManWidth-1];
	assign roundBit = prodHigh ? product[ManWidth-1] : product[ManWidth-2];
	assign sticky = prodHigh ? |product[ManWidth-2:0] : |product[ManWidth-3:0];

	always_ff @(posedge clk) begin
		{manA1, manB1} <= {manA, manB};
		{expSum1, sign1, specialResult1, specialValid1, invalid1} <=
			{expSum, sign, specialResult, specialValid, invalid};
		{specialResult2, specialValid2, invalid2, sign2} <=
			{specialResult1, specialValid1, invalid1, sign1};
		roundM2 <= normM;
		roundMP2 <= normM + 1'b1;
		roundE2 <= normE;
		roundEP2 <= normE + 1'b1;
		roundUp2 <= guard && (roundBit || sticky || normM[0]);	// Ties to even
		inexact2 <= guard || roundBit || sticky;
		if (valid2) fifoMem[wrPtr] <= fifoData;
	end

	fpMulRound round_i (.roundM(roundM2), .roundMP(roundMP2), .roundE(roundE2),
		.roundEP(roundEP2), .sign(sign2), .roundUp(roundUp2), .inexact(inexact2),
		.result(roundResult), .flags(roundFlags));

	always_comb begin
		specialFlags = '0;
		specialFlags[FlagInvalid] = invalid2;
		fifoData = specialValid2 ? {specialResult2, specialFlags} : {roundResult, roundFlags};
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			{valid1, valid2, wrPtr, rdPtr, fifoCnt} <= '0;
		end else begin
			valid1 <= issueValid;
			valid2 <= valid1;
			wrPtr <= wrPtr + LanePtrWidth'(valid2);
			rdPtr <= rdPtr + LanePtrWidth'(lanePop);
			fifoCnt <= fifoCnt + LaneCntWidth'(valid2) - LaneCntWidth'(lanePop);
		end
	end

	assign laneValid = fifoCnt != '0;
	assign {laneResult, laneFlags} = fifoMem[rdPtr];

	// Dispatcher credits keep the FIFO from overflowing
	assert property (@(posedge clk) disable iff (!arstN)
		valid2 |-> fifoCnt != LaneCntWidth'(LaneDepth));

endmodule

//--- source/fpMulCollect.sv
`timescale 1ns/1ps

module fpMulCollect import fpMulPkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic [NumLanes-1:0] laneValid,
	input  logic [NumLanes-1:0][DataWidth-1:0] laneResult,
	input  logic [NumLanes-1:0][FlagWidth-1:0] laneFlags,
	output logic [NumLanes-1:0] lanePop,
	output logic [NumLanes-1:0] laneCredit,
	output logic outValid,
	output logic [DataWidth-1:0] outResult,
	output logic [FlagWidth-1:0] outFlags,
	input  logic outCredit
);

	logic [LaneIdxWidth-1:0] rrPtr;				// Same lane order as the dispatcher
	logic [OutCntWidth-1:0] outCnt;
	logic pop;

	// Waits on the lane in turn, so issue order is kept
	assign pop = laneValid[rrPtr] && (outCnt != '0);

	always_comb begin
		lanePop = '0;
		lanePop[rrPtr] = pop;
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			outResult <= laneResult[rrPtr];
			outFlags <= laneFlags[rrPtr];
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rrPtr <= '0;
			outCnt <= OutCntWidth'(OutCredits);
			outValid <= 1'b0;
			laneCredit <= '0;
		end else begin
			outValid <= pop;
			laneCredit <= lanePop;				// Slot freed in that lane's FIFO
			outCnt <= outCnt + OutCntWidth'(outCredit) - OutCntWidth'(pop);
			if (pop) begin
				rrPtr <= (rrPtr == LaneIdxWidth'(NumLanes - 1)) ? '0 : rrPtr + 1'b1;
			end
		end
	end

	// Each beat was paid for by a credit held the cycle before
	assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> $past(outCnt) != '0);

	// Sink returns no more credits than it was given
	assert property (@(posedge clk) disable iff (!arstN)
		outCnt <= OutCntWidth'(OutCredits));

endmodule

//--- source/fpMulArray.sv
`timescale 1ns/1ps

module fpMulArray import fpMulPkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	input  logic [DataWidth-1:0] inA,
	input  logic [DataWidth-1:0] inB,
	output logic inCredit,
	output logic outValid,
	output logic [DataWidth-1:0] outResult,
	output logic [FlagWidth-1:0] outFlags,
	input  logic outCredit
);

	logic [NumLanes-1:0] issueValid;
	logic [NumLanes-1:0][DataWidth-1:0] issueA;
	logic [NumLanes-1:0][DataWidth-1:0] issueB;
	logic [NumLanes-1:0] laneCredit;
	logic [NumLanes-1:0] laneValid;
	logic [NumLanes-1:0][DataWidth-1:0] laneResult;
	logic [NumLanes-1:0][FlagWidth-1:0] laneFlags;
	logic [NumLanes-1:0] lanePop;

	fpMulDispatch dispatch_i (.clk, .arstN, .inValid, .inA, .inB, .inCredit,
		.issueValid, .issueA, .issueB, .laneCredit);

	for (genvar gi = 0; gi < NumLanes; gi++) begin : genLane
		fpMulLane lane_i (
			.clk,
			.arstN,
			.issueValid(issueValid[gi]),
			.issueA(issueA[gi]),
			.issueB(issueB[gi]),
			.laneValid(laneValid[gi]),
			.laneResult(laneResult[gi]),
			.laneFlags(laneFlags[gi]),
			.lanePop(lanePop[gi])
		);
	end

	fpMulCollect collect_i (.clk, .arstN, .laneValid, .laneResult, .laneFlags,
		.lanePop, .laneCredit, .outValid, .outResult, .outFlags, .outCredit);

endmodule

//--- tests/fpMulArrayTb.sv
`timescale 1ns/1ps

module fpMulArrayTb import fpMulPkg::*; ();

	localparam int HalfPeriod = 4;				// 8 ns clock
	localparam int NumRandom = 40;
	localparam int NumSpecial = 8;
	localparam int NumRounding = 8;
	localparam int NumRange = 5;
	localparam int NumHold = 28;				// More than the array can buffer
	localparam int TotalOps = NumRandom + NumSpecial + NumRounding + NumRange + NumHold;

	logic clk = 1'b0;
	logic arstN;
	logic inValid;
	logic [DataWidth-1:0] inA;
	logic [DataWidth-1:0] inB;
	logic inCredit;
	logic outValid;
	logic [DataWidth-1:0] outResult;
	logic [FlagWidth-1:0] outFlags;
	logic outCredit = 1'b0;

	logic [DataWidth-1:0] expRes [TotalOps];
	logic [FlagWidth-1:0] expFlags [TotalOps];
	logic [31:0] rngState = 32'hc23d_d5b0;
	int sent = 0;						// Pairs driven into the DUT
	int returned = 0;					// inCredit pulses seen
	int outIdx = 0;						// Results received
	int creditAvail;
	int errCount = 0;
	int errMark = 0;
	int owed = 0;						// Credits the sink still has to give back
	int holdBeats = 0;
	logic holdPhase = 1'b0;

	fpMulArray dut_i (.clk, .arstN, .inValid, .inA, .inB, .inCredit,
		.outValid, .outResult, .outFlags, .outCredit);

	always #HalfPeriod clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [DataWidth-1:0] randNormal(input logic [31:0] r);
		logic [ExpWidth-1:0] e;
		e = {1'b0, r[20:17]} + 5'd8;			// Exponents 8 to 23 so some products overflow
		return {r[31], e, r[9:0]};
	endfunction

	// Reference binary16 multiply, nearest even, subnormals flushed
	function automatic logic [DataWidth+FlagWidth-1:0] modelMul(input logic [DataWidth-1:0] a,
			input logic [DataWidth-1:0] b);
		int ea, eb, e, drop, p, kept, rem, half;
		logic s;
		logic [FlagWidth-1:0] f;
		bit aZero, bZero, aInf, bInf, aNaN, bNaN;
		s = a[DataWidth-1] ^ b[DataWidth-1];
		ea = int'(a[DataWidth-2 -: ExpWidth]);
		eb = int'(b[DataWidth-2 -: ExpWidth]);
		aZero = (ea == 0);
		bZero = (eb == 0);
		aInf = (ea == ExpMax) && (a[ManWidth-1:0] == '0);
		bInf = (eb == ExpMax) && (b[ManWidth-1:0] == '0);
		aNaN = (ea == ExpMax) && (a[ManWidth-1:0] != '0);
		bNaN = (eb == ExpMax) && (b[ManWidth-1:0] != '0);
		f = '0;
		if (aNaN || bNaN || (aInf && bZero) || (aZero && bInf)) begin
			f[FlagInvalid] = 1'b1;
			return {CanonNaN, f};
		end
		if (aInf || bInf) begin
			return {s, {ExpWidth{1'b1}}, {ManWidth{1'b0}}, f};
		end
		if (aZero || bZero) begin
			return {s, {(DataWidth-1){1'b0}}, f};
		end
		p = ((1 << ManWidth) + int'(a[ManWidth-1:0])) * ((1 << ManWidth) + int'(b[ManWidth-1:0]));
		e = ea + eb - ExpBias;
		drop = ManWidth;
		if (p >= (1 << (2 * ManWidth + 1))) begin	// Product of 2.0 or more
			drop = ManWidth + 1;
			e = e + 1;
		end
		kept = p >> drop;
		rem = p - (kept << drop);
		half = 1 << (drop - 1);
		f[FlagInexact] = (rem != 0);
		if ((rem > half) || ((rem == half) && (kept % 2 == 1))) begin
			kept = kept + 1;
		end
		if (kept == (2 << ManWidth)) begin		// Rounded up to 2.0
			kept = 1 << ManWidth;
			e = e + 1;
		end
		if (e >= ExpMax) begin
			f[FlagOverflow] = 1'b1;
			f[FlagInexact] = 1'b1;
			return {s, {ExpWidth{1'b1}}, {ManWidth{1'b0}}, f};
		end
		if (e <= 0) begin
			f[FlagUnderflow] = 1'b1;
			f[FlagInexact] = 1'b1;
			return {s, {(DataWidth-1){1'b0}}, f};
		end
		return {s, ExpWidth'(e), ManWidth'(kept - (1 << ManWidth)), f};
	endfunction

	always_comb creditAvail = InQueueDepth + returned - sent;

	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			returned <= 0;
			outIdx <= 0;
		end else begin
			if (inCredit) returned <= returned + 1;
			if (outValid) outIdx <= outIdx + 1;
		end
	end

	always @(posedge clk) begin
		if (!holdPhase) holdBeats <= 0;
		else if (outValid) holdBeats <= holdBeats + 1;
	end

	// Sink gives one credit back per consumed result unless it holds them
	always @(negedge clk) begin
		if (outValid) owed = owed + 1;
		if (!holdPhase && (owed > 0)) begin
			outCredit = 1'b1;
			owed = owed - 1;
		end else begin
			outCredit = 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> (outResult == expRes[outIdx]) && (outFlags == expFlags[outIdx]))
	else begin
		$display("mismatch at %0t: result %h flags %b, model %h flags %b", $time,
			$sampled(outResult), $sampled(outFlags), expRes[$sampled(outIdx)],
			expFlags[$sampled(outIdx)]);
		errCount++;
	end

	assert property (@(posedge clk) disable iff (!arstN) outValid |-> outIdx < sent)
	else begin
		$display("a result came out with no operand pair outstanding at %0t", $time);
		errCount++;
	end

	// DUT returns no credit for a pair it never took
	assert property (@(posedge clk) disable iff (!arstN)
		(creditAvail >= 0) && (creditAvail <= InQueueDepth))
	else begin
		$display("the input credit count left the range 0 to %0d at %0t", InQueueDepth, $time);
		errCount++;
	end

	assert property (@(posedge clk) disable iff (!arstN) holdBeats <= OutCredits)
	else begin
		$display("more than %0d results left while the sink held its credits", OutCredits);
		errCount++;
	end

	task automatic sendPair(input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b);
		logic [DataWidth+FlagWidth-1:0] expd;
		expd = modelMul(a, b);
		expRes[sent] = expd[FlagWidth +: DataWidth];
		expFlags[sent] = expd[FlagWidth-1:0];
		while (creditAvail <= 0) @(negedge clk);	// Wait for a returned credit
		inValid = 1'b1;
		inA = a;
		inB = b;
		sent++;
		@(negedge clk);
		inValid = 1'b0;
	endtask

	task automatic sendRandom(input int count);
		logic [DataWidth-1:0] a, b;
		for (int i = 0; i < count; i++) begin
			rngState = xorshift(rngState);
			a = randNormal(rngState);
			rngState = xorshift(rngState);
			b = randNormal(rngState);
			sendPair(a, b);
		end
	endtask

	task automatic finishTest(input string name, input int ops);
		while (outIdx != sent) @(negedge clk);
		$display("%s: %0d operands, %0d errors", name, ops, errCount - errMark);
		errMark = errCount;
	endtask

	initial begin
		arstN = 1'b0;
		inValid = 1'b0;
		inA = '0;
		inB = '0;
		repeat (10) @(negedge clk);
		arstN = 1'b1;
		assert (!inCredit && !outValid)
		else begin
			$display("inCredit or outValid high right after reset");
			errCount++;
		end

		sendRandom(NumRandom);
		finishTest("random normals", NumRandom);

		sendPair(16'h7E00, 16'h3C00);			// Quiet NaN
		sendPair(16'h3C00, 16'h7C01);			// Signaling NaN
		sendPair(16'h7C00, 16'h0000);			// inf * 0
		sendPair(16'h8000, 16'hFC00);
		sendPair(16'hFC00, 16'h4000);			// -inf * 2
		sendPair(16'h7C00, 16'h8001);			// Subnormal counts as zero
		sendPair(16'h8000, 16'h4500);
		sendPair(16'h0001, 16'hC000);
		finishTest("special operands", NumSpecial);

		sendPair(16'h3E00, 16'h3C01);			// Odd tie rounds up
		sendPair(16'h3E00, 16'h3C03);			// Even tie stays
		sendPair(16'hBC01, 16'h3E00);
		sendPair(16'h3DA8, 16'h3DA8);			// Rounds up to 2.0
		sendPair(16'h4000, 16'h4200);			// Exact
		sendPair(16'h3C00, 16'h3C00);
		sendPair(16'h3C01, 16'h3C01);
		sendPair(16'h3FFF, 16'h3FFF);
		finishTest("rounding", NumRounding);

		sendPair(16'h7BFF, 16'h7BFF);			// Overflow
		sendPair(16'hF800, 16'h4000);
		sendPair(16'h0400, 16'h3800);			// Underflow
		sendPair(16'h8400, 16'h0400);
		sendPair(16'h7800, 16'h3BFF);			// Largest range still in reach
		finishTest("overflow and underflow", NumRange);

		while (owed != 0) @(negedge clk);
		holdPhase <= 1'b1;
		fork
			sendRandom(NumHold);
			begin
				repeat (80) @(negedge clk);
				holdPhase <= 1'b0;
			end
		join
		finishTest("back-pressure", NumHold);

		repeat (4) @(negedge clk);
		assert (returned == sent)
		else begin
			$display("mismatch at %0t: %0d inCredit pulses for %0d accepted pairs", $time,
				returned, sent);
			errCount++;
		end
		finishTest("credits", sent);

		$display("%0d results checked, %0d errors", outIdx, errCount);
		if (errCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		repeat (TotalOps * 40 + 10) @(posedge clk);
		$display("watchdog expired with %0d of %0d results received", outIdx, sent);
		$display("Test failed");
		$finish;
	end

endmodule

//--- fpMulArray.f
source/fpMulPkg.sv
source/fpMulDispatch.sv
source/fpMulPrepare.sv
source/fpMulRound.sv
source/fpMulLane.sv
source/fpMulCollect.sv
source/fpMulArray.sv
tests/fpMulArrayTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the fpMulArray testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fpMulArrayTb \
	-f fpMulArray.f -o simFpMul \
	&& ./obj_dir/simFpMul > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
